// File: dv/rv_core_tb.sv
// testbench for the rv64i core: random programs, a reference model and store checks
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb;
  import rv_core_pkg::*;

  localparam int MEM_WORDS   = 256;
  localparam int BODY_LEN    = 24;
  localparam int RAND_RUNS   = 3;
  localparam int PROG_LEN    = BODY_LEN + NUM_REGS + 1;
  localparam int ILL_LEN     = 4;
  localparam int CYCLE_LIMIT = 4 * (RAND_RUNS * PROG_LEN + ILL_LEN) + 100;

  logic  clk;
  logic  rst_n;
  inst_t inst;
  xlen_t pc;
  logic  dmem_wen;
  xlen_t dmem_addr;
  xlen_t dmem_wdata;
  logic  halt;
  logic  illegal;

  inst_t       imem [MEM_WORDS];
  int          prog_len;
  logic [31:0] rng_state = 32'd31;
  xlen_t       m_regs [NUM_REGS];
  xlen_t       m_pc;
  logic        m_halted;
  logic        m_illegal;
  logic        checking;
  xlen_t       dut_stores;
  xlen_t       ref_stores;
  int          cycles = 0;
  string       test_name;
  logic        exp_st;
  xlen_t       exp_addr;
  xlen_t       exp_data;
  xlen_t       exp_next;

  initial clk = 1'b0;
  always #10 clk = ~clk;

  rv_core rv_core_i (
    .i_clk        (clk),
    .i_rst_n      (rst_n),
    .i_inst       (inst),
    .o_pc         (pc),
    .o_dmem_wen   (dmem_wen),
    .o_dmem_addr  (dmem_addr),
    .o_dmem_wdata (dmem_wdata),
    .o_halt       (halt),
    .o_illegal    (illegal)
  );

  function automatic logic [7:0] mem_index(input xlen_t a);
    xlen_t w;
    w = (a - RESET_PC) >> 2;
    return w[7:0];
  endfunction

  // instruction memory answers the fetch address within the cycle
  always_comb begin
    inst = imem[mem_index(pc)];
  end

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string what, input xlen_t exp, input xlen_t act);
    if (act !== exp) begin
      fail_now($sformatf("[FAIL] %s: %s expected %h actual %h", test_name, what, exp, act));
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      fail_now($sformatf("[FAIL] %s: %s expected %b actual %b", test_name, what, exp, act));
    end
  endtask

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  // executes one instruction on the model state by the rv64i rules
  function automatic void ref_exec(input inst_t w, output logic st, output xlen_t addr,
                                   output xlen_t data, output xlen_t nxt);
    xlen_t i_imm;
    xlen_t s_imm;
    xlen_t u_imm;
    xlen_t j_imm;
    xlen_t wr_val;
    logic  wr;
    logic  stop;
    logic  bad;
    i_imm = $signed(w[31:20]);
    s_imm = $signed({w[31:25], w[11:7]});
    u_imm = $signed({w[31:12], 12'h000});
    j_imm = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0});
    st = 1'b0;
    addr = '0;
    data = '0;
    wr = 1'b0;
    wr_val = '0;
    stop = 1'b0;
    bad = 1'b0;
    nxt = m_pc + 64'd4;
    case (w[6:0])
      OPC_LUI: begin
        wr = 1'b1;
        wr_val = u_imm;
      end
      OPC_AUIPC: begin
        wr = 1'b1;
        wr_val = m_pc + u_imm;
      end
      OPC_JAL: begin
        wr = 1'b1;
        wr_val = m_pc + 64'd4;
        nxt = m_pc + j_imm;
      end
      OPC_OPIMM: begin
        wr = (w[14:12] == 3'b000);
        bad = !wr;
        wr_val = m_regs[w[19:15]] + i_imm;
      end
      OPC_STORE: begin
        st = (w[14:12] == 3'b011);
        bad = !st;
        addr = m_regs[w[19:15]] + s_imm;
        data = m_regs[w[24:20]];
      end
      OPC_SYSTEM: begin
        stop = (w == 32'h0010_0073);
        bad = !stop;
      end
      default: bad = 1'b1;
    endcase
    if (bad || stop) begin
      m_halted = 1'b1;
      m_illegal = bad;
      nxt = m_pc;
      wr = 1'b0;
    end
    if (wr && w[11:7] != 5'd0) begin
      m_regs[w[11:7]] = wr_val;
    end
  endfunction

  // compares the DUT against the model once per cycle, before the edge commits
  always @(posedge clk) begin
    if (checking && rst_n) begin
      check_word("pc", m_pc, pc);
      check_flag("halt", m_halted, halt);
      check_flag("illegal", m_illegal, illegal);
      if (dmem_wen) begin
        dut_stores = dut_stores + 1;
      end
      if (m_halted) begin
        check_flag("store strobe while halted", 1'b0, dmem_wen);
      end else begin
        ref_exec(imem[mem_index(m_pc)], exp_st, exp_addr, exp_data, exp_next);
        check_flag("store strobe", exp_st, dmem_wen);
        if (exp_st) begin
          ref_stores = ref_stores + 1;
          check_word("store address", exp_addr, dmem_addr);
          check_word("store data", exp_data, dmem_wdata);
        end
        m_pc = exp_next;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      fail_now($sformatf("timeout: the core did not finish within %0d cycles", cycles));
    end
  end

  task automatic emit(input inst_t w);
    imem[prog_len] = w;
    prog_len = prog_len + 1;
  endtask

  task automatic clear_memory();
    int a;
    for (a = 0; a < MEM_WORDS; a++) begin
      imem[a] = 32'hffff_0000 ^ a;
    end
    prog_len = 0;
  endtask

  task automatic build_random_program();
    logic [31:0] r;
    logic [11:0] imm12;
    logic [20:0] joff;
    int          i;
    int          kind;
    int          skip;
    clear_memory();
    r = next_rand();
    emit({r[31:12], 5'd1, OPC_LUI});
    for (i = 1; i < BODY_LEN; i++) begin
      kind = next_rand() % 5;
      skip = 1 + next_rand() % 3;
      r = next_rand();
      imm12 = r[31:20];
      joff = 21'(4 * skip);
      if (kind == 0) begin
        emit({r[31:12], r[11:7], OPC_LUI});
      end else if (kind == 1) begin
        emit({r[31:12], r[11:7], OPC_AUIPC});
      end else if (kind == 3 && i + skip <= BODY_LEN) begin
        emit({joff[20], joff[10:1], joff[11], joff[19:12], r[11:7], OPC_JAL});
      end else if (kind == 4) begin
        emit({imm12[11:5], r[24:20], r[19:15], F3_SD, imm12[4:0], OPC_STORE});
      end else begin
        emit({imm12, r[19:15], F3_ADDI, r[11:7], OPC_OPIMM});
      end
    end
    // dump every register, x0 included, to consecutive doublewords
    for (i = 0; i < NUM_REGS; i++) begin
      imm12 = 12'(i * 8);
      emit({imm12[11:5], 5'(i), 5'd0, F3_SD, imm12[4:0], OPC_STORE});
    end
    emit(32'h0010_0073);
  endtask

  task automatic build_illegal_program();
    clear_memory();
    emit({20'h12345, 5'd5, OPC_LUI});
    emit({12'h007, 5'd5, F3_ADDI, 5'd6, OPC_OPIMM});
    // slti x5, x0, 1 lies outside the subset and must leave x5 alone
    emit({12'h001, 5'd0, 3'b010, 5'd5, OPC_OPIMM});
    emit(32'h0010_0073);
  endtask

  task automatic reset_core(input string name);
    int r;
    test_name = name;
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (7) @(posedge clk);
    @(negedge clk);
    check_word("reset pc", RESET_PC, pc);
    check_flag("reset store strobe", 1'b0, dmem_wen);
    check_flag("reset halt", 1'b0, halt);
    check_flag("reset illegal", 1'b0, illegal);
    for (r = 0; r < NUM_REGS; r++) begin
      m_regs[r] = '0;
    end
    m_pc = RESET_PC;
    m_halted = 1'b0;
    m_illegal = 1'b0;
    dut_stores = '0;
    ref_stores = '0;
    checking = 1'b1;
    @(posedge clk);
    rst_n <= 1'b1;
  endtask

  task automatic finish_program(input logic exp_illegal);
    int r;
    do begin
      @(negedge clk);
    end while (!halt);
    check_flag("illegal flag", exp_illegal, illegal);
    repeat (20) @(negedge clk);
    check_word("pc frozen after halt", m_pc, pc);
    check_word("store count", ref_stores, dut_stores);
    for (r = 1; r < NUM_REGS; r++) begin
      check_word($sformatf("register x%0d", r), m_regs[r], rv_core_i.u_regfile.regs[r]);
    end
    checking = 1'b0;
  endtask

  initial begin
    int run;
    rst_n = 1'b0;
    checking = 1'b0;
    for (run = 0; run < RAND_RUNS; run++) begin
      build_random_program();
      reset_core($sformatf("random program %0d", run));
      finish_program(1'b0);
    end
    build_illegal_program();
    reset_core("illegal instruction");
    finish_program(1'b1);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/rv_core.sv
// rv64i single-cycle core top: decode, register file, execute and pc units
`timescale 1ns/1ps
`default_nettype none

module rv_core (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  rv_core_pkg::inst_t i_inst,
  output rv_core_pkg::xlen_t o_pc,
  output logic               o_dmem_wen,
  output rv_core_pkg::xlen_t o_dmem_addr,
  output rv_core_pkg::xlen_t o_dmem_wdata,
  output logic               o_halt,
  output logic               o_illegal
);
  import rv_core_pkg::*;

  xlen_t rs1_data;
  xlen_t rs2_data;
  xlen_t result;
  xlen_t target;
  logic  jump;
  logic  halt_req;
  logic  illegal_req;
  logic  commit;

  rv_dec_if dec_bus ();

  rv_idu u_idu (
    .i_inst (i_inst),
    .dec    (dec_bus)
  );

  rv_regfile u_regfile (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .rf       (dec_bus),
    .i_wdata  (result),
    .i_wen_ok (commit),
    .o_rs1    (rs1_data),
    .o_rs2    (rs2_data)
  );

  rv_exu u_exu (
    .i_pc          (o_pc),
    .i_rs1         (rs1_data),
    .i_rs2         (rs2_data),
    .i_commit      (commit),
    .ex            (dec_bus),
    .o_result      (result),
    .o_jump        (jump),
    .o_target      (target),
    .o_halt_req    (halt_req),
    .o_illegal_req (illegal_req),
    .o_store       (o_dmem_wen),
    .o_store_addr  (o_dmem_addr),
    .o_store_data  (o_dmem_wdata)
  );

  rv_pc_unit u_pc_unit (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_jump        (jump),
    .i_target      (target),
    .i_halt_req    (halt_req),
    .i_illegal_req (illegal_req),
    .o_pc          (o_pc),
    .o_halted      (o_halt),
    .o_illegal     (o_illegal),
    .o_commit      (commit)
  );

endmodule

`default_nettype wire

// File: logic/rv_core_pkg.sv
// rv64i core package: data widths, instruction encodings and control field codes
`default_nettype none

package rv_core_pkg;

  localparam int XLEN     = 64;
  localparam int ILEN     = 32;
  localparam int REG_AW   = 5;
  localparam int NUM_REGS = 32;

  typedef logic [XLEN-1:0]   xlen_t;
  typedef logic [ILEN-1:0]   inst_t;
  typedef logic [REG_AW-1:0] reg_idx_t;

  // immediate format select
  typedef logic [2:0] imm_fmt_t;
  localparam imm_fmt_t IMM_I = 3'b000;
  localparam imm_fmt_t IMM_U = 3'b001;
  localparam imm_fmt_t IMM_S = 3'b010;
  localparam imm_fmt_t IMM_J = 3'b100;

  // alu operation, halt and illegal share the code space so the execute unit
  // can raise its requests straight from the operation code
  typedef logic [3:0] alu_ctr_t;
  localparam alu_ctr_t ALU_ADD     = 4'b0000;
  localparam alu_ctr_t ALU_COPY_B  = 4'b0011;
  localparam alu_ctr_t ALU_HALT    = 4'b1110;
  localparam alu_ctr_t ALU_ILLEGAL = 4'b1111;

  // operand b source
  typedef logic [1:0] op_b_sel_t;
  localparam op_b_sel_t OPB_RS2  = 2'b00;
  localparam op_b_sel_t OPB_IMM  = 2'b01;
  localparam op_b_sel_t OPB_FOUR = 2'b10;

  // major opcodes
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // funct3 codes
  localparam logic [2:0] F3_ADDI = 3'b000;
  localparam logic [2:0] F3_SD   = 3'b011;
  localparam logic [2:0] F3_PRIV = 3'b000;

  // one instruction is four bytes, used for the link value and the sequential pc
  localparam xlen_t PC_STEP = 64'd4;

  localparam xlen_t RESET_PC = 64'h0000_0000_8000_0000;

endpackage

`default_nettype wire

// File: logic/rv_dec_if.sv
// decoded control bundle from the decoder to the execute unit and register file
`timescale 1ns/1ps
`default_nettype none

interface rv_dec_if;
  import rv_core_pkg::*;

  xlen_t     imm;
  reg_idx_t  ra;
  reg_idx_t  rb;
  reg_idx_t  rd;
  logic      wen;
  logic      a_is_pc;
  op_b_sel_t b_sel;
  alu_ctr_t  alu_ctr;
  logic      is_store;
  logic      is_jump;

  modport dec (
    output imm, ra, rb, rd, wen, a_is_pc, b_sel, alu_ctr, is_store, is_jump
  );

  modport exu (
    input imm, a_is_pc, b_sel, alu_ctr, is_store, is_jump
  );

  modport rf (
    input ra, rb, rd, wen
  );

endinterface

`default_nettype wire

// File: logic/rv_exu.sv
// execute unit: operand select, alu, jump target and store address and data
`timescale 1ns/1ps
`default_nettype none

module rv_exu (
  input  rv_core_pkg::xlen_t i_pc,
  input  rv_core_pkg::xlen_t i_rs1,
  input  rv_core_pkg::xlen_t i_rs2,
  input  logic               i_commit,
  rv_dec_if.exu              ex,
  output rv_core_pkg::xlen_t o_result,
  output logic               o_jump,
  output rv_core_pkg::xlen_t o_target,
  output logic               o_halt_req,
  output logic               o_illegal_req,
  output logic               o_store,
  output rv_core_pkg::xlen_t o_store_addr,
  output rv_core_pkg::xlen_t o_store_data
);
  import rv_core_pkg::*;

  xlen_t op_a;
  xlen_t op_b;
  xlen_t sum;

  assign op_a = ex.a_is_pc ? i_pc : i_rs1;

  always_comb begin
    case (ex.b_sel)
      OPB_RS2:  op_b = i_rs2;
      OPB_IMM:  op_b = ex.imm;
      OPB_FOUR: op_b = PC_STEP;
      default:  op_b = '0;
    endcase
  end

  assign sum = op_a + op_b;

  always_comb begin
    case (ex.alu_ctr)
      ALU_ADD:    o_result = sum;
      ALU_COPY_B: o_result = op_b;
      default:    o_result = '0;
    endcase
  end

  // jal uses operand b for the link value, so the target needs its own adder
  assign o_jump   = ex.is_jump;
  assign o_target = i_pc + ex.imm;

  assign o_halt_req    = (ex.alu_ctr == ALU_HALT);
  assign o_illegal_req = (ex.alu_ctr == ALU_ILLEGAL);

  // sd: address is rs1 + imm, data is rs2 as a whole doubleword
  assign o_store      = ex.is_store && i_commit;
  assign o_store_addr = sum;
  assign o_store_data = i_rs2;

endmodule

`default_nettype wire

// File: logic/rv_idu.sv
// instruction decode: classifies lui, auipc, jal, addi, sd and ebreak into control fields
`timescale 1ns/1ps
`default_nettype none

module rv_idu (
  input rv_core_pkg::inst_t i_inst,
  rv_dec_if.dec             dec
);
  import rv_core_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       inst_lui;
  logic       inst_auipc;
  logic       inst_jal;
  logic       inst_addi;
  logic       inst_sd;
  logic       inst_ebreak;
  logic       type_u;
  logic       type_s;
  logic       type_j;
  imm_fmt_t   imm_fmt;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];

  assign dec.ra = i_inst[19:15];
  assign dec.rb = i_inst[24:20];
  assign dec.rd = i_inst[11:7];

  assign inst_lui    = (opcode == OPC_LUI);
  assign inst_auipc  = (opcode == OPC_AUIPC);
  assign inst_jal    = (opcode == OPC_JAL);
  assign inst_addi   = (opcode == OPC_OPIMM)  && (funct3 == F3_ADDI);
  assign inst_sd     = (opcode == OPC_STORE)  && (funct3 == F3_SD);
  assign inst_ebreak = (opcode == OPC_SYSTEM) && (funct3 == F3_PRIV);

  assign type_u = inst_lui | inst_auipc;
  assign type_s = inst_sd;
  assign type_j = inst_jal;

  always_comb begin
    if (type_j) begin
      imm_fmt = IMM_J;
    end else if (type_s) begin
      imm_fmt = IMM_S;
    end else if (type_u) begin
      imm_fmt = IMM_U;
    end else begin
      imm_fmt = IMM_I;
    end
  end

  rv_imm_gen u_imm_gen (
    .i_inst (i_inst),
    .i_fmt  (imm_fmt),
    .o_imm  (dec.imm)
  );

  // ebreak and illegal words never write a register
  assign dec.wen     = inst_lui | inst_auipc | inst_jal | inst_addi;
  assign dec.a_is_pc = inst_auipc | inst_jal;

  // jal writes the link value pc + 4, the target is formed separately in the execute unit
  always_comb begin
    if (type_j) begin
      dec.b_sel = OPB_FOUR;
    end else if (type_u | type_s | inst_addi) begin
      dec.b_sel = OPB_IMM;
    end else begin
      dec.b_sel = OPB_RS2;
    end
  end

  always_comb begin
    if (inst_lui) begin
      dec.alu_ctr = ALU_COPY_B;
    end else if (inst_auipc | inst_jal | inst_addi | inst_sd) begin
      dec.alu_ctr = ALU_ADD;
    end else if (inst_ebreak) begin
      dec.alu_ctr = ALU_HALT;
    end else begin
      dec.alu_ctr = ALU_ILLEGAL;
    end
  end

  assign dec.is_store = inst_sd;
  assign dec.is_jump  = inst_jal;

  // the opcode and funct3 compares must never overlap, or the
  // priority order above would silently pick one class
  always_comb begin
    a_match_onehot: assert #0 (
      $onehot0({inst_lui, inst_auipc, inst_jal, inst_addi, inst_sd, inst_ebreak})
    ) else $error("more than one instruction match for %h", i_inst);
  end

endmodule

`default_nettype wire

// File: logic/rv_imm_gen.sv
// immediate generator: builds the sign-extended i, u, s and j immediates and picks one
`timescale 1ns/1ps
`default_nettype none

module rv_imm_gen (
  input  rv_core_pkg::inst_t    i_inst,
  input  rv_core_pkg::imm_fmt_t i_fmt,
  output rv_core_pkg::xlen_t    o_imm
);
  import rv_core_pkg::*;

  xlen_t imm_i;
  xlen_t imm_u;
  xlen_t imm_s;
  xlen_t imm_j;

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};

  // u immediate is a 32-bit value, sign extended to the full word on rv64
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};

  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};

  // jal offset bits are scattered across the word, bit 0 is always zero
  assign imm_j = {
    {44{i_inst[31]}},
    i_inst[19:12],
    i_inst[20],
    i_inst[30:21],
    1'b0
  };

  always_comb begin
    case (i_fmt)
      IMM_I:   o_imm = imm_i;
      IMM_U:   o_imm = imm_u;
      IMM_S:   o_imm = imm_s;
      IMM_J:   o_imm = imm_j;
      default: o_imm = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/rv_pc_unit.sv
// program counter: next-pc select, halt and illegal latches, retire enable
`timescale 1ns/1ps
`default_nettype none

module rv_pc_unit (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_jump,
  input  rv_core_pkg::xlen_t i_target,
  input  logic               i_halt_req,
  input  logic               i_illegal_req,
  output rv_core_pkg::xlen_t o_pc,
  output logic               o_halted,
  output logic               o_illegal,
  output logic               o_commit
);
  import rv_core_pkg::*;

  xlen_t pc_q;
  logic  halted_q;
  logic  illegal_q;

  // the current instruction may retire only while running and not halting now
  assign o_commit = !halted_q && !i_halt_req && !i_illegal_req;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      pc_q      <= RESET_PC;
      halted_q  <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      if (o_commit) begin
        pc_q <= i_jump ? i_target : pc_q + PC_STEP;
      end
      if (!halted_q && (i_halt_req || i_illegal_req)) begin
        halted_q  <= 1'b1;
        illegal_q <= i_illegal_req;
      end
    end
  end

  assign o_pc      = pc_q;
  assign o_halted  = halted_q;
  assign o_illegal = illegal_q;

  a_pc_aligned: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) o_pc[1:0] == 2'b00
  ) else $error("pc %h is not word aligned", o_pc);

endmodule

`default_nettype wire

// File: logic/rv_regfile.sv
// register file: 32 x 64-bit, two combinational read ports, one write port, x0 reads zero
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  logic               i_clk,
  input  logic               i_rst_n,
  rv_dec_if.rf               rf,
  input  rv_core_pkg::xlen_t i_wdata,
  input  logic               i_wen_ok,
  output rv_core_pkg::xlen_t o_rs1,
  output rv_core_pkg::xlen_t o_rs2
);
  import rv_core_pkg::*;

  // only x1 to x31 have storage
  xlen_t regs [1:NUM_REGS-1];
  logic  do_write;

  assign do_write = rf.wen && i_wen_ok && (rf.rd != '0);

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (do_write) begin
      regs[rf.rd] <= i_wdata;
    end
  end

  always_comb begin
    if (rf.ra == '0) begin
      o_rs1 = '0;
    end else begin
      o_rs1 = regs[rf.ra];
    end
  end

  always_comb begin
    if (rf.rb == '0) begin
      o_rs2 = '0;
    end else begin
      o_rs2 = regs[rf.rb];
    end
  end

  // a write aimed at x0 in one cycle must not show up on a later read
  a_x0_zero: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (rf.wen && rf.rd == '0) ##1 (rf.ra == '0) |-> (o_rs1 == '0)
  ) else $error("x0 read back nonzero after a write to x0");

endmodule

`default_nettype wire

// File: sources.f
logic/rv_core_pkg.sv
logic/rv_dec_if.sv
logic/rv_imm_gen.sv
logic/rv_idu.sv
logic/rv_regfile.sv
logic/rv_exu.sv
logic/rv_pc_unit.sv
logic/rv_core.sv
dv/rv_core_tb.sv
